/* source/armPkg.sv */
package armPkg;

  // ==============================
  // Widths with a meaning
  // ==============================

  // Data, address and instruction word
  typedef logic [31:0] wordT;

  // Register index, where r15 is the PC
  typedef logic [3:0] regAddrT;

  // Immediate shift amount from bits 11:7
  typedef logic [4:0] shAmtT;

  // Fetch advance per cycle
  localparam wordT pcStep = 32'd4;

  // ==============================
  // Encodings
  // ==============================

  // Data-processing opcode field, bits 24:21
  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opMvn = 4'b1111
  } aluOpT;

  // Shift type field, bits 6:5
  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shTypeT;

  // Branch shadow tracking
  typedef enum logic [1:0] {
    stRun    = 2'b00,
    stFlush1 = 2'b01,
    stFlush2 = 2'b10
  } flushStateT;

endpackage

/* source/pcCounter.sv */
module pcCounter #(
  parameter armPkg::wordT resetPc = '0
) (
  input  logic         clk,
  input  logic         arstN,
  input  logic         branchTaken,
  input  armPkg::wordT branchTarget,
  output armPkg::wordT pcF
);

  import armPkg::*;

  // Sequential fetch address
  wordT pcNext;

  // Branch target wins over the step
  assign pcNext = branchTaken ? branchTarget : pcF + pcStep;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcF <= resetPc;
    end else begin
      pcF <= pcNext;
    end
  end

endmodule

/* source/pipeControl.sv */
module pipeControl (
  input  logic            clk,
  input  logic            arstN,
  input  armPkg::wordT    instrE,
  input  logic            validE,
  output armPkg::aluOpT   aluOp,
  output armPkg::shTypeT  shType,
  output armPkg::shAmtT   shAmt,
  output logic            useImm,
  output logic            regWriteE,
  output logic            branchTaken,
  output logic            flush
);

  import armPkg::*;

  flushStateT state;
  flushStateT stateNext;

  // Instruction class from bits 27:25
  logic isDataProc;
  logic isBranch;

  // Execute slot holds a real instruction
  logic liveE;

  // ==============================
  // Execute decode
  // ==============================

  assign isDataProc = (instrE[27:26] == 2'b00);
  assign isBranch   = (instrE[27:25] == 3'b101);

  // Valid slot outside the branch shadow
  assign liveE = validE && (state == stRun);

  // Opcode and shifter fields straight from the word
  assign aluOp  = aluOpT'(instrE[24:21]);
  assign shType = shTypeT'(instrE[6:5]);
  assign shAmt  = instrE[11:7];
  // I bit selects the rotated immediate
  assign useImm = instrE[25];

  // Condition field and S bit are not looked at
  assign regWriteE   = liveE && isDataProc;
  assign branchTaken = liveE && isBranch;

  // Kill the two younger instructions at the redirect edge
  assign flush = branchTaken;

  // ==============================
  // Flush FSM
  // ==============================

  always_comb begin
    stateNext = state;
    case (state)
      stRun: begin
        if (branchTaken) begin
          stateNext = stFlush1;
        end
      end
      // Execute holds the bubble from the old decode slot
      stFlush1: stateNext = stFlush2;
      // Execute holds the bubble from the old fetch slot
      stFlush2: stateNext = stRun;
      default:  stateNext = stRun;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stRun;
    end else begin
      state <= stateNext;
    end
  end

endmodule

/* source/regFile.sv */
module regFile (
  input  logic            clk,
  input  logic            arstN,
  input  armPkg::regAddrT ra1,
  input  armPkg::regAddrT ra2,
  input  logic            we,
  input  armPkg::regAddrT wa,
  input  armPkg::wordT    wd,
  input  armPkg::wordT    pcPlus8,
  output armPkg::wordT    rd1,
  output armPkg::wordT    rd2
);

  import armPkg::*;

  // r0 to r14, r15 lives in the PC counter
  wordT regs [15];

  // One read port with PC view and write-through
  function automatic wordT readPort(input regAddrT ra);
    wordT value;
    if (ra == 4'd15) begin
      value = pcPlus8;
    end else if (we && (wa == ra)) begin
      value = wd;
    end else begin
      value = regs[ra];
    end
    return value;
  endfunction

  // Both ports follow the array, the PC view and the write port
  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != 4'd15)) begin
      // Writes to r15 are dropped
      regs[wa] <= wd;
    end
  end

endmodule

/* source/execUnit.sv */
module execUnit (
  input  armPkg::wordT   srcA,
  input  armPkg::wordT   srcB,
  input  armPkg::wordT   imm12,
  input  armPkg::aluOpT  aluOp,
  input  armPkg::shTypeT shType,
  input  armPkg::shAmtT  shAmt,
  input  logic           useImm,
  output armPkg::wordT   aluResult
);

  import armPkg::*;

  // Immediate rotator
  logic [4:0]  rotAmt;
  logic [63:0] immPair;
  wordT        immRot;

  // Barrel shifter
  logic [63:0] rorPair;
  wordT        shifted;

  // Operand B into the ALU
  wordT opB;

  // ==============================
  // Operand B
  // ==============================

  // Rotate right by twice the 4-bit field
  assign rotAmt  = {imm12[11:8], 1'b0};
  assign immPair = {24'd0, imm12[7:0], 24'd0, imm12[7:0]} >> rotAmt;
  assign immRot  = immPair[31:0];

  // Doubled word makes ROR a plain right shift
  assign rorPair = {srcB, srcB} >> shAmt;

  always_comb begin
    case (shType)
      shLsl:   shifted = srcB << shAmt;
      shLsr:   shifted = srcB >> shAmt;
      shAsr:   shifted = wordT'($signed(srcB) >>> shAmt);
      shRor:   shifted = rorPair[31:0];
      default: shifted = srcB;
    endcase
  end

  assign opB = useImm ? immRot : shifted;

  // ==============================
  // ALU
  // ==============================

  always_comb begin
    case (aluOp)
      opAnd:   aluResult = srcA & opB;
      opEor:   aluResult = srcA ^ opB;
      opSub:   aluResult = srcA - opB;
      // Reverse subtract
      opRsb:   aluResult = opB - srcA;
      opAdd:   aluResult = srcA + opB;
      opOrr:   aluResult = srcA | opB;
      opMov:   aluResult = opB;
      opMvn:   aluResult = ~opB;
      default: aluResult = opB;
    endcase
  end

endmodule

/* source/datapath.sv */
module datapath (
  // From fetch
  input  logic            clk,
  input  logic            arstN,
  input  armPkg::wordT    instrF,
  input  armPkg::wordT    pcF,
  // From control
  input  logic            flush,
  input  logic            regWriteE,
  // From execute unit and register file
  input  armPkg::wordT    aluResult,
  input  armPkg::wordT    rd1,
  input  armPkg::wordT    rd2,
  // To control and execute unit
  output armPkg::wordT    instrE,
  output armPkg::wordT    pcD,
  output armPkg::wordT    pcE,
  output armPkg::wordT    srcA,
  output armPkg::wordT    srcB,
  output armPkg::wordT    branchTarget,
  output armPkg::wordT    resultW,
  output logic            validE,
  output logic            regWriteW,
  // To register file
  output armPkg::regAddrT ra1,
  output armPkg::regAddrT ra2,
  output armPkg::regAddrT waW
);

  import armPkg::*;

  // Decode register
  wordT instrD;
  logic validD;

  // Execute operands before forwarding
  wordT    rd1E;
  wordT    rd2E;
  regAddrT rnE;
  regAddrT rmE;
  logic    fwdA;
  logic    fwdB;

  // Word offset of B, sign extended and scaled
  wordT branchOffset;

  // ==============================
  // Decode stage
  // ==============================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrD <= '0;
      pcD    <= '0;
      validD <= 1'b0;
    end else begin
      instrD <= instrF;
      pcD    <= pcF;
      // Wrong-path fetch turns into a bubble
      validD <= !flush;
    end
  end

  // Rn and Rm fields
  assign ra1 = instrD[19:16];
  assign ra2 = instrD[3:0];

  // ==============================
  // Execute stage
  // ==============================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrE <= '0;
      pcE    <= '0;
      rd1E   <= '0;
      rd2E   <= '0;
      validE <= 1'b0;
    end else begin
      instrE <= instrD;
      pcE    <= pcD;
      rd1E   <= rd1;
      rd2E   <= rd2;
      validE <= validD && !flush;
    end
  end

  // Writeback forwarding, r15 always comes from the PC
  assign rnE  = instrE[19:16];
  assign rmE  = instrE[3:0];
  assign fwdA = regWriteW && (waW == rnE) && (rnE != 4'd15);
  assign fwdB = regWriteW && (waW == rmE) && (rmE != 4'd15);
  assign srcA = fwdA ? resultW : rd1E;
  assign srcB = fwdB ? resultW : rd2E;

  // Target is pcE plus 8 plus offset times 4
  assign branchOffset = {{6{instrE[23]}}, instrE[23:0], 2'b00};
  assign branchTarget = pcE + (pcStep << 1) + branchOffset;

  // ==============================
  // Writeback stage
  // ==============================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resultW   <= '0;
      waW       <= '0;
      regWriteW <= 1'b0;
    end else begin
      resultW   <= aluResult;
      // Rd field
      waW       <= instrE[15:12];
      regWriteW <= regWriteE;
    end
  end

endmodule

/* source/armCore.sv */
module armCore #(
  parameter armPkg::wordT resetPc = '0
) (
  input  logic            clk,
  input  logic            arstN,
  input  armPkg::wordT    instrF,
  output armPkg::wordT    pcF,
  output logic            regWriteW,
  output armPkg::regAddrT waW,
  output armPkg::wordT    resultW
);

  import armPkg::*;

  // Control to datapath and execute unit
  aluOpT   aluOp;
  shTypeT  shType;
  shAmtT   shAmt;
  logic    useImm;
  logic    regWriteE;
  logic    branchTaken;
  logic    flush;

  // Pipeline values
  wordT    instrE;
  wordT    pcD;
  wordT    pcE;
  wordT    srcA;
  wordT    srcB;
  wordT    branchTarget;
  wordT    aluResult;
  logic    validE;

  // Register file ports
  regAddrT ra1;
  regAddrT ra2;
  wordT    rd1;
  wordT    rd2;

  pcCounter #(
    .resetPc(resetPc)
  ) uPc (
    .clk(clk),
    .arstN(arstN),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .pcF(pcF)
  );

  pipeControl uCtrl (
    .clk(clk),
    .arstN(arstN),
    .instrE(instrE),
    .validE(validE),
    .aluOp(aluOp),
    .shType(shType),
    .shAmt(shAmt),
    .useImm(useImm),
    .regWriteE(regWriteE),
    .branchTaken(branchTaken),
    .flush(flush)
  );

  // r15 reads see the decode PC plus 8
  regFile uRf (
    .clk(clk),
    .arstN(arstN),
    .ra1(ra1),
    .ra2(ra2),
    .we(regWriteW),
    .wa(waW),
    .wd(resultW),
    .pcPlus8(pcD + 32'd8),
    .rd1(rd1),
    .rd2(rd2)
  );

  // Low 12 bits of the execute word hold rotate and imm8
  execUnit uExec (
    .srcA(srcA),
    .srcB(srcB),
    .imm12({20'd0, instrE[11:0]}),
    .aluOp(aluOp),
    .shType(shType),
    .shAmt(shAmt),
    .useImm(useImm),
    .aluResult(aluResult)
  );

  datapath uDp (
    .clk(clk),
    .arstN(arstN),
    .instrF(instrF),
    .pcF(pcF),
    .flush(flush),
    .regWriteE(regWriteE),
    .aluResult(aluResult),
    .rd1(rd1),
    .rd2(rd2),
    .instrE(instrE),
    .pcD(pcD),
    .pcE(pcE),
    .srcA(srcA),
    .srcB(srcB),
    .branchTarget(branchTarget),
    .resultW(resultW),
    .validE(validE),
    .regWriteW(regWriteW),
    .ra1(ra1),
    .ra2(ra2),
    .waW(waW)
  );

endmodule

/* dv/armCore_props.sv */
module armCoreProps (
  input logic               clk,
  input logic               arstN,
  input logic               regWriteW,
  input logic               regWriteE,
  input logic               validE,
  input logic               branchTaken,
  input armPkg::flushStateT state
);

  timeunit 1ns;
  timeprecision 100ps;

  import armPkg::*;

  // Running count of assertion failures
  int failCount = 0;

  // ==============================
  // Pipeline control invariants
  // ==============================

  // No writeback strobe while reset is held across an edge
  noWriteInReset: assert property (@(posedge clk) (!arstN && !$past(arstN)) |-> !regWriteW)
    else begin
      $error("writeback strobe while reset is held");
      failCount++;
    end

  // First slot behind a taken branch is a bubble with no write
  quietSlot1: assert property (@(posedge clk) disable iff (!arstN)
                               branchTaken |=> (!validE && !regWriteE))
    else begin
      $error("live slot or write enable in the first flushed slot");
      failCount++;
    end

  // Second slot behind a taken branch is a bubble with no write
  quietSlot2: assert property (@(posedge clk) disable iff (!arstN)
                               $past(branchTaken, 2) |-> (!validE && !regWriteE))
    else begin
      $error("live slot or write enable in the second flushed slot");
      failCount++;
    end

  // Flush FSM always passes through stFlush1
  noSkip: assert property (@(posedge clk) disable iff (!arstN)
                           (state == stRun) |=> (state != stFlush2))
    else begin
      $error("flush FSM jumped from stRun to stFlush2");
      failCount++;
    end

endmodule

bind armCore armCoreProps props (
  .clk(clk),
  .arstN(arstN),
  .regWriteW(regWriteW),
  .regWriteE(regWriteE),
  .validE(validE),
  .branchTaken(branchTaken),
  .state(uCtrl.state)
);

/* dv/armCoreTb.sv */
module armCoreTb;

  timeunit 1ns;
  timeprecision 100ps;

  import armPkg::*;

  // ==============================
  // Sizes and limits
  // ==============================

  // Words in the data file image
  localparam int dataDepth = 256;
  // Instruction memory, indexed by pcF[7:2]
  localparam int memDepth = 64;
  // Marks the end of the expected writeback list
  localparam wordT endMark = 32'hFFFF_FFFF;

  logic    clk;
  logic    arstN;
  wordT    instrF;
  wordT    pcF;
  logic    regWriteW;
  regAddrT waW;
  wordT    resultW;

  // Raw file image and the program view of it
  wordT testData [dataDepth];
  wordT instrMem [memDepth];

  // Layout of the expected list inside testData
  int progLen;
  int expBase;
  int expCount;

  // Progress and error counts
  int retired;
  int cycleCount;
  int cycleLimit;
  int valueErrors;
  int otherFailures;
  int assertFailures;

  armCore #(
    .resetPc(32'd0)
  ) uut (
    .clk(clk),
    .arstN(arstN),
    .instrF(instrF),
    .pcF(pcF),
    .regWriteW(regWriteW),
    .waW(waW),
    .resultW(resultW)
  );

  // Fetch returns the word in the same cycle
  assign instrF = instrMem[pcF[7:2]];

  always #4 clk = ~clk;

  task automatic compareValue(input string what, input int slot,
                              input wordT actual, input wordT expected);
    if (actual !== expected) begin
      $display("error at %0t: writeback %0d %s is %08h, expected %08h",
               $time, slot, what, actual, expected);
      valueErrors++;
    end
  endtask

  task automatic loadTestData();
    int i;
    int off;
    $readmemh("dv/testdata.txt", testData);
    progLen = int'(testData[0]);
    if ((progLen < 2) || (progLen > memDepth - 2)) begin
      $display("failure: dv/testdata.txt holds no usable program length");
      otherFailures++;
      progLen = 0;
    end
    for (i = 0; i < memDepth; i++) begin
      // Past the program, each word branches back to the last program word
      off = progLen - 3 - i;
      instrMem[i] = (i < progLen) ? testData[i + 1] : {8'hEA, off[23:0]};
    end
    expBase  = progLen + 1;
    expCount = 0;
    if (progLen > 0) begin
      while ((expBase + 2 * expCount + 1 < dataDepth) &&
             (testData[expBase + 2 * expCount] !== endMark)) begin
        expCount++;
      end
    end
  endtask

  // ==============================
  // Writeback checker
  // ==============================

  // regWriteW is a register output, so the pre-edge value is the pulse
  always @(posedge clk) begin
    if (regWriteW) begin
      if (retired < expCount) begin
        compareValue("register", retired, wordT'(waW), testData[expBase + 2 * retired]);
        compareValue("value", retired, resultW, testData[expBase + 2 * retired + 1]);
      end else begin
        $display("failure: unexpected writeback of %08h to r%0d at %0t",
                 resultW, waW, $time);
        otherFailures++;
      end
      retired++;
    end
  end

  initial begin
    clk            = 1'b0;
    arstN          = 1'b0;
    retired        = 0;
    cycleCount     = 0;
    valueErrors    = 0;
    otherFailures  = 0;
    assertFailures = 0;
    loadTestData();
    // Three cycles per instruction covers the pipeline fill and branch shadows
    cycleLimit = 3 * progLen + 20;
    repeat (3) @(posedge clk);
    arstN <= 1'b1;
    while ((retired < expCount) && (cycleCount < cycleLimit)) begin
      @(negedge clk);
      cycleCount++;
    end
    if (retired < expCount) begin
      $display("failure: timeout after %0d cycles with %0d of %0d writebacks seen",
               cycleCount, retired, expCount);
      otherFailures++;
    end
    // Halt loop runs on, so late extra writebacks still show up
    repeat (4) @(negedge clk);
    assertFailures = uut.props.failCount;
    $display("writebacks %0d of %0d, value errors %0d, other failures %0d, assertions %0d",
             retired, expCount, valueErrors, otherFailures, assertFailures);
    if ((valueErrors == 0) && (otherFailures == 0) && (assertFailures == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* dv/testdata.txt */
// Word 0 is the program length N, then N instruction words from address 0
// Then pairs of register index and written value in retirement order, ffffffff ends them
0000001d
// Rotated immediates, one wrapping across bit 0
e3a010ff e3a024ff e2813e3f e3a042ff
// MVN of an immediate, then LSL LSR ASR ROR and a zero shift of it
e3e0507e e1a06205 e1a07425 e1a08245 e1a09665 e1a0a005
// Chain where each word uses the previous result
e281b001 e08bb00b e24bc010 e08cc10b e02cb00b
// SUB RSB AND ORR EOR MVN
e0431001 e2612000 e0023004 e1834221 e22450ff e1e06005
// Branch over two words to the third
ea000001 e3a07011 e3a08022 e3a09033
// r15 as Rn and as Rm, use of the branch target result, halt loop
e28fa000 e1a0b08f e089c00a eafffffe
// Expected writebacks
1 000000ff 2 ff000000 3 000004ef 4 f000000f
5 ffffff81 6 fffff810 7 00ffffff 8 fffffff8 9 f81fffff a ffffff81
b 00000100 b 00000200 c 000001f0 c 000009f0 b 00000bf0
1 000003f0 2 fffffc10 3 f0000000 4 f000003f 5 f00000c0 6 0fffff3f
9 00000033
a 0000006c b 000000e0 c 0000009f
ffffffff

/* sources.f */
source/armPkg.sv
source/pcCounter.sv
source/pipeControl.sv
source/regFile.sv
source/execUnit.sv
source/datapath.sv
source/armCore.sv
dv/armCore_props.sv
dv/armCoreTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = armCoreTb
FILELIST = sources.f
BUILD    = obj_dir
RUNFLAGS = +verilator+error+limit+1000
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
